//--- verilog/mips_pkg.sv
package mips_pkg;

    localparam int NUM_REGS   = 32;                    // general purpose registers.
    localparam int NUM_CP0    = 8;                     // cp0 registers visible over apb.
    localparam int CP0_ADDR_W = $clog2(NUM_CP0);       // index width for the cp0 array.
    localparam int APB_ADDR_W = CP0_ADDR_W + 1;        // one extra bit for the enable register.

    // The enable register sits just past the last cp0 word.
    localparam logic [APB_ADDR_W-1:0] CP0_ENABLE_ADDR = APB_ADDR_W'(NUM_CP0);

    typedef logic [31:0] word_t;                       // one data word.
    typedef logic [4:0]  reg_addr_t;                   // general register index.

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_ADDU,
        ALU_SUB,
        ALU_SUBU,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI,
        ALU_PASSB
    } alufunc_t;

    typedef enum logic [3:0] {
        OP_ALU,                                        // plain alu result to rd.
        OP_MOVZ,
        OP_MOVN,
        OP_MFHI,
        OP_MFLO,
        OP_MTHI,
        OP_MTLO,
        OP_MFC0,
        OP_LINK                                        // jal style return address.
    } decoded_op_t;

    typedef enum logic {
        SRC_REGB,
        SRC_IMM
    } alusrc_t;

endpackage

//--- verilog/alu.sv
module alu (
    input  mips_pkg::word_t    a,
    input  mips_pkg::word_t    b,
    input  mips_pkg::alufunc_t func,
    output mips_pkg::word_t    result,
    output logic               overflow
);
    import mips_pkg::*;

    word_t sum;
    word_t diff;
    logic  add_ovf;
    logic  sub_ovf;

    assign sum  = a + b;
    assign diff = a - b;

    // Signed overflow: operand signs agree but the result sign does not.
    assign add_ovf = (a[31] == b[31]) && (sum[31] != a[31]);
    assign sub_ovf = (a[31] != b[31]) && (diff[31] != a[31]);

    always_comb
    begin
        result   = '0;
        overflow = 1'b0;
        case (func)
            ALU_ADD:   begin
                result   = sum;
                overflow = add_ovf;
            end
            ALU_ADDU:  result = sum;
            ALU_SUB:   begin
                result   = diff;
                overflow = sub_ovf;
            end
            ALU_SUBU:  result = diff;
            ALU_AND:   result = a & b;
            ALU_OR:    result = a | b;
            ALU_XOR:   result = a ^ b;
            ALU_NOR:   result = ~(a | b);
            ALU_SLT:   result = {31'b0, $signed(a) < $signed(b)};
            ALU_SLTU:  result = {31'b0, a < b};
            ALU_SLL:   result = b << a[4:0];           // shift amount rides in operand a.
            ALU_SRL:   result = b >> a[4:0];
            ALU_SRA:   result = word_t'($signed(b) >>> a[4:0]);
            ALU_LUI:   result = {b[15:0], 16'b0};
            ALU_PASSB: result = b;
            default:   result = '0;
        endcase
    end

endmodule

//--- verilog/delay_fu.sv
module delay_fu (
    input  mips_pkg::decoded_op_t op,
    input  mips_pkg::alufunc_t    func,
    input  mips_pkg::alusrc_t     alusrc,
    input  logic                  shamt_valid,
    input  logic [4:0]            shamt,
    input  mips_pkg::word_t       imm,
    input  logic                  readya,
    input  logic                  readyb,
    input  mips_pkg::word_t       srca,
    input  mips_pkg::word_t       srcb,
    input  logic                  regwrite_in,
    input  mips_pkg::word_t       pcplus4,
    input  mips_pkg::word_t       reg_dataa,
    input  mips_pkg::word_t       reg_datab,
    input  mips_pkg::word_t       hi_data,
    input  mips_pkg::word_t       lo_data,
    input  mips_pkg::word_t       cp0_data,
    output mips_pkg::word_t       result,
    output mips_pkg::word_t       hiresult,
    output mips_pkg::word_t       loresult,
    output logic                  regwrite,
    output logic                  exception_of
);
    import mips_pkg::*;

    word_t opa;
    word_t opb;
    word_t alu_a;
    word_t alu_b;
    word_t alu_result;
    word_t pcplus8;
    logic  alu_ovf;
    logic  ovf;

    // A forwarded value wins; otherwise hi, lo or cp0 replace the register read.
    assign opa = readya            ? srca     :
                 (op == OP_MFHI)   ? hi_data  :
                 (op == OP_MFLO)   ? lo_data  :
                 (op == OP_MFC0)   ? cp0_data : reg_dataa;
    assign opb = readyb ? srcb : reg_datab;

    assign alu_a = shamt_valid ? {27'b0, shamt} : opa;
    assign alu_b = (alusrc == SRC_REGB) ? opb : imm;

    alu u_alu (
        .a        (alu_a),
        .b        (alu_b),
        .func     (func),
        .result   (alu_result),
        .overflow (alu_ovf)
    );

    assign pcplus8 = pcplus4 + 32'd4;                  // return address skips the delay slot.
    assign ovf     = alu_ovf && (op == OP_ALU);

    always_comb
    begin
        case (op)
            OP_ALU:  result = alu_result;
            OP_LINK: result = pcplus8;
            default: result = opa;                     // moves copy rs, hi, lo or cp0.
        endcase
    end

    always_comb
    begin
        case (op)
            OP_MOVZ: regwrite = (alu_b == '0);
            OP_MOVN: regwrite = (alu_b != '0);
            default: regwrite = regwrite_in && !ovf;   // an overflowing add must not land in rd.
        endcase
    end

    assign hiresult     = (op == OP_MTHI) ? opa : hi_data;
    assign loresult     = (op == OP_MTLO) ? opa : lo_data;
    assign exception_of = ovf;

endmodule

//--- verilog/reg_file.sv
module reg_file (
    input  logic                clk,
    input  logic                rst_n,
    input  mips_pkg::reg_addr_t raddr_a,
    input  mips_pkg::reg_addr_t raddr_b,
    output mips_pkg::word_t     rdata_a,
    output mips_pkg::word_t     rdata_b,
    input  logic                we,
    input  mips_pkg::reg_addr_t waddr,
    input  mips_pkg::word_t     wdata
);
    import mips_pkg::*;

    word_t regs [NUM_REGS];

    // Reads are combinational; a write lands on the next edge.
    assign rdata_a = regs[raddr_a];
    assign rdata_b = regs[raddr_b];

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < NUM_REGS; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (we && (waddr != '0))                  // $zero is hardwired.
        begin
            regs[waddr] <= wdata;
        end
    end

endmodule

//--- verilog/cp0_apb_regs.sv
module cp0_apb_regs (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 psel,
    input  logic                                 penable,
    input  logic                                 pwrite,
    input  logic [mips_pkg::APB_ADDR_W-1:0]      paddr,
    input  mips_pkg::word_t                      pwdata,
    output mips_pkg::word_t                      prdata,
    output logic                                 pready,
    input  logic [mips_pkg::CP0_ADDR_W-1:0]      cp0_addr,
    output mips_pkg::word_t                      cp0_data,
    output logic                                 enable
);
    import mips_pkg::*;

    word_t cp0_regs [NUM_CP0];
    logic  wr_en;
    logic  addr_is_cp0;

    assign pready      = 1'b1;                         // no wait states.
    assign wr_en       = psel && penable && pwrite;
    assign addr_is_cp0 = (paddr < APB_ADDR_W'(NUM_CP0));

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < NUM_CP0; i++)
            begin
                cp0_regs[i] <= '0;
            end
            enable <= 1'b0;
        end
        else if (wr_en)
        begin
            if (addr_is_cp0)
            begin
                cp0_regs[paddr[CP0_ADDR_W-1:0]] <= pwdata;
            end
            else if (paddr == CP0_ENABLE_ADDR)
            begin
                enable <= pwdata[0];
            end
        end
    end

    // Read data is driven from the address alone, so it is ready in the access phase.
    always_comb
    begin
        if (addr_is_cp0)
            prdata = cp0_regs[paddr[CP0_ADDR_W-1:0]];
        else if (paddr == CP0_ENABLE_ADDR)
            prdata = {31'b0, enable};
        else
            prdata = '0;                               // unmapped words read as zero.
    end

    assign cp0_data = cp0_regs[cp0_addr];

endmodule

//--- verilog/delay_stage.sv
module delay_stage (
    input  logic                            clk,
    input  logic                            rst_n,
    // instruction input
    input  logic                            in_valid,
    input  mips_pkg::decoded_op_t           in_op,
    input  mips_pkg::alufunc_t              in_func,
    input  mips_pkg::alusrc_t               in_alusrc,
    input  logic                            in_shamt_valid,
    input  logic [4:0]                      in_shamt,
    input  mips_pkg::word_t                 in_imm,
    input  mips_pkg::reg_addr_t             in_srcrega,
    input  mips_pkg::reg_addr_t             in_srcregb,
    input  mips_pkg::reg_addr_t             in_destreg,
    input  logic                            in_readya,
    input  logic                            in_readyb,
    input  mips_pkg::word_t                 in_srca,
    input  mips_pkg::word_t                 in_srcb,
    input  logic                            in_regwrite,
    input  mips_pkg::word_t                 in_pcplus4,
    input  logic [mips_pkg::CP0_ADDR_W-1:0] in_cp0_addr,
    // result output
    output logic                            out_valid,
    output mips_pkg::word_t                 out_result,
    output mips_pkg::word_t                 out_hiresult,
    output mips_pkg::word_t                 out_loresult,
    output mips_pkg::reg_addr_t             out_destreg,
    output logic                            out_regwrite,
    output logic                            out_exception_of,
    // apb configuration port
    input  logic                            psel,
    input  logic                            penable,
    input  logic                            pwrite,
    input  logic [mips_pkg::APB_ADDR_W-1:0] paddr,
    input  mips_pkg::word_t                 pwdata,
    output mips_pkg::word_t                 prdata,
    output logic                            pready
);
    import mips_pkg::*;

    word_t hi_reg;
    word_t lo_reg;
    word_t rf_dataa;
    word_t rf_datab;
    word_t cp0_data;
    word_t fu_result;
    word_t fu_hiresult;
    word_t fu_loresult;
    logic  fu_regwrite;
    logic  fu_exception_of;
    logic  stage_enable;
    logic  wb_en;
    logic  rf_we;

    // Writeback and out_valid share this term, so a disabled stage drops the instruction.
    assign wb_en = in_valid && stage_enable;
    assign rf_we = wb_en && fu_regwrite;

    reg_file u_reg_file (
        .clk     (clk),
        .rst_n   (rst_n),
        .raddr_a (in_srcrega),
        .raddr_b (in_srcregb),
        .rdata_a (rf_dataa),
        .rdata_b (rf_datab),
        .we      (rf_we),
        .waddr   (in_destreg),
        .wdata   (fu_result)
    );

    cp0_apb_regs u_cp0_apb_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .cp0_addr (in_cp0_addr),
        .cp0_data (cp0_data),
        .enable   (stage_enable)
    );

    delay_fu u_delay_fu (
        .op           (in_op),
        .func         (in_func),
        .alusrc       (in_alusrc),
        .shamt_valid  (in_shamt_valid),
        .shamt        (in_shamt),
        .imm          (in_imm),
        .readya       (in_readya),
        .readyb       (in_readyb),
        .srca         (in_srca),
        .srcb         (in_srcb),
        .regwrite_in  (in_regwrite),
        .pcplus4      (in_pcplus4),
        .reg_dataa    (rf_dataa),
        .reg_datab    (rf_datab),
        .hi_data      (hi_reg),
        .lo_data      (lo_reg),
        .cp0_data     (cp0_data),
        .result       (fu_result),
        .hiresult     (fu_hiresult),
        .loresult     (fu_loresult),
        .regwrite     (fu_regwrite),
        .exception_of (fu_exception_of)
    );

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            hi_reg           <= '0;
            lo_reg           <= '0;
            out_valid        <= 1'b0;
            out_regwrite     <= 1'b0;
            out_exception_of <= 1'b0;
        end
        else
        begin
            if (wb_en && (in_op == OP_MTHI))
                hi_reg <= fu_hiresult;
            if (wb_en && (in_op == OP_MTLO))
                lo_reg <= fu_loresult;
            out_valid        <= wb_en;
            out_regwrite     <= rf_we;
            out_exception_of <= wb_en && fu_exception_of;
        end
    end

    // Payload only matters while out_valid is high.
    always_ff @(posedge clk)
    begin
        out_result   <= fu_result;
        out_hiresult <= fu_hiresult;
        out_loresult <= fu_loresult;
        out_destreg  <= in_destreg;
    end

endmodule

//--- bench/delay_stage_sva.sv
module delay_stage_sva (
    input logic                            clk,
    input logic                            rst_n,
    input logic                            in_valid,
    input mips_pkg::decoded_op_t           in_op,
    input mips_pkg::alufunc_t              in_func,
    input mips_pkg::alusrc_t               in_alusrc,
    input logic                            in_shamt_valid,
    input logic [4:0]                      in_shamt,
    input mips_pkg::word_t                 in_imm,
    input mips_pkg::reg_addr_t             in_srcrega,
    input mips_pkg::reg_addr_t             in_srcregb,
    input mips_pkg::reg_addr_t             in_destreg,
    input logic                            in_readya,
    input logic                            in_readyb,
    input mips_pkg::word_t                 in_srca,
    input mips_pkg::word_t                 in_srcb,
    input logic                            in_regwrite,
    input mips_pkg::word_t                 in_pcplus4,
    input logic [mips_pkg::CP0_ADDR_W-1:0] in_cp0_addr,
    input logic                            out_valid,
    input mips_pkg::word_t                 out_result,
    input mips_pkg::word_t                 out_hiresult,
    input mips_pkg::word_t                 out_loresult,
    input mips_pkg::reg_addr_t             out_destreg,
    input logic                            out_regwrite,
    input logic                            out_exception_of,
    input logic                            psel,
    input logic                            penable,
    input logic                            pwrite,
    input logic [mips_pkg::APB_ADDR_W-1:0] paddr,
    input mips_pkg::word_t                 pwdata,
    input logic                            pready
);
    import mips_pkg::*;

    word_t       shadow_regs [NUM_REGS];
    word_t       shadow_cp0 [NUM_CP0];
    word_t       shadow_hi;
    word_t       shadow_lo;
    logic        shadow_en;
    word_t       opa;
    word_t       opb;
    word_t       a;
    word_t       b;
    word_t       alu_val;
    word_t       want_result;
    logic [32:0] wide;
    logic        want_of;
    logic        want_we;
    logic        accept;
    logic        exp_valid;
    logic        exp_we;
    logic        exp_of;
    word_t       exp_result;
    word_t       exp_hi;
    word_t       exp_lo;
    reg_addr_t   exp_destreg;
    int unsigned n_valid = 0;
    int unsigned n_regwrite = 0;
    int unsigned n_exc = 0;
    int unsigned n_result = 0;
    int unsigned n_hi = 0;
    int unsigned n_lo = 0;
    int unsigned n_dest = 0;
    int unsigned n_ready = 0;
    int unsigned fail_count;

    assign fail_count = n_valid + n_regwrite + n_exc + n_result + n_hi + n_lo
                        + n_dest + n_ready;

    always_comb
    begin
        if (in_readya)
            opa = in_srca;                             // forwarded value wins over every source.
        else if (in_op == OP_MFHI)
            opa = shadow_hi;
        else if (in_op == OP_MFLO)
            opa = shadow_lo;
        else if (in_op == OP_MFC0)
            opa = shadow_cp0[in_cp0_addr];
        else
            opa = shadow_regs[in_srcrega];
        opb  = in_readyb ? in_srcb : shadow_regs[in_srcregb];
        a    = in_shamt_valid ? {27'b0, in_shamt} : opa;
        b    = (in_alusrc == SRC_IMM) ? in_imm : opb;
        wide = (in_func == ALU_SUB) ? {a[31], a} - {b[31], b} : {a[31], a} + {b[31], b};
        case (in_func)
            ALU_ADD, ALU_ADDU: alu_val = a + b;
            ALU_SUB, ALU_SUBU: alu_val = a - b;
            ALU_AND:           alu_val = a & b;
            ALU_OR:            alu_val = a | b;
            ALU_XOR:           alu_val = a ^ b;
            ALU_NOR:           alu_val = ~(a | b);
            ALU_SLT:           alu_val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_SLTU:          alu_val = (a < b) ? 32'd1 : 32'd0;
            ALU_SLL:           alu_val = b << a[4:0];
            ALU_SRL:           alu_val = b >> a[4:0];
            ALU_SRA:           alu_val = word_t'({{32{b[31]}}, b} >> a[4:0]);
            ALU_LUI:           alu_val = {b[15:0], 16'h0};
            default:           alu_val = b;
        endcase
        // a 33 bit sum whose top two bits differ has left the signed range.
        want_of = (in_op == OP_ALU) && (in_func inside {ALU_ADD, ALU_SUB}) && (wide[32] != wide[31]);
        if (in_op == OP_ALU)
            want_result = alu_val;
        else if (in_op == OP_LINK)
            want_result = in_pcplus4 + 32'd4;
        else
            want_result = opa;
        if (in_op == OP_MOVZ)
            want_we = (b == 32'h0);
        else if (in_op == OP_MOVN)
            want_we = (b != 32'h0);
        else
            want_we = in_regwrite && !want_of;
        accept = in_valid && shadow_en;
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < NUM_REGS; i++)
            begin
                shadow_regs[i] <= '0;
            end
            for (int i = 0; i < NUM_CP0; i++)
            begin
                shadow_cp0[i] <= '0;
            end
            shadow_hi <= '0;
            shadow_lo <= '0;
            shadow_en <= 1'b0;
            exp_valid <= 1'b0;
            exp_we    <= 1'b0;
            exp_of    <= 1'b0;
        end
        else
        begin
            if (psel && penable && pwrite)
            begin
                if (paddr < APB_ADDR_W'(NUM_CP0))
                    shadow_cp0[paddr[CP0_ADDR_W-1:0]] <= pwdata;
                else if (paddr == CP0_ENABLE_ADDR)
                    shadow_en <= pwdata[0];
            end
            if (accept && want_we && (in_destreg != 5'd0))
                shadow_regs[in_destreg] <= want_result;
            if (accept && (in_op == OP_MTHI))
                shadow_hi <= opa;
            if (accept && (in_op == OP_MTLO))
                shadow_lo <= opa;
            exp_valid   <= accept;
            exp_we      <= accept && want_we;
            exp_of      <= accept && want_of;
            exp_result  <= want_result;
            exp_hi      <= (in_op == OP_MTHI) ? opa : shadow_hi;
            exp_lo      <= (in_op == OP_MTLO) ? opa : shadow_lo;
            exp_destreg <= in_destreg;
        end
    end

    a_valid: assert property (@(posedge clk) disable iff (!rst_n) out_valid == exp_valid)
        else
        begin
            n_valid++;
            $error("mismatch t=%0t out_valid got %b exp %b", $time,
                   $sampled(out_valid), $sampled(exp_valid));
        end

    a_regwrite: assert property (@(posedge clk) disable iff (!rst_n) out_regwrite == exp_we)
        else
        begin
            n_regwrite++;
            $error("mismatch t=%0t out_regwrite got %b exp %b", $time,
                   $sampled(out_regwrite), $sampled(exp_we));
        end

    a_exc: assert property (@(posedge clk) disable iff (!rst_n) out_exception_of == exp_of)
        else
        begin
            n_exc++;
            $error("mismatch t=%0t out_exception_of got %b exp %b", $time,
                   $sampled(out_exception_of), $sampled(exp_of));
        end

    a_result: assert property (@(posedge clk) disable iff (!rst_n)
                               out_valid |-> out_result == exp_result)
        else
        begin
            n_result++;
            $error("mismatch t=%0t out_result got %h exp %h", $time,
                   $sampled(out_result), $sampled(exp_result));
        end

    a_hi: assert property (@(posedge clk) disable iff (!rst_n)
                           out_valid |-> out_hiresult == exp_hi)
        else
        begin
            n_hi++;
            $error("mismatch t=%0t out_hiresult got %h exp %h", $time,
                   $sampled(out_hiresult), $sampled(exp_hi));
        end

    a_lo: assert property (@(posedge clk) disable iff (!rst_n)
                           out_valid |-> out_loresult == exp_lo)
        else
        begin
            n_lo++;
            $error("mismatch t=%0t out_loresult got %h exp %h", $time,
                   $sampled(out_loresult), $sampled(exp_lo));
        end

    a_destreg: assert property (@(posedge clk) disable iff (!rst_n)
                                out_valid |-> out_destreg == exp_destreg)
        else
        begin
            n_dest++;
            $error("mismatch t=%0t out_destreg got %0d exp %0d", $time,
                   $sampled(out_destreg), $sampled(exp_destreg));
        end

    // the slave never inserts wait states.
    a_pready: assert property (@(posedge clk) disable iff (!rst_n) (psel && penable) |-> pready)
        else
        begin
            n_ready++;
            $error("mismatch t=%0t pready got %b exp 1", $time, $sampled(pready));
        end

endmodule

//--- bench/delay_stage_tb.sv
module delay_stage_tb;
    import mips_pkg::*;

    localparam int N_RAND  = 200;                      // random alu ops on register operands.
    localparam int N_READY = 60;
    localparam int N_MOV   = 40;
    localparam int N_INSTR = 8 + 2 * N_RAND + 2 * NUM_REGS + N_READY + N_MOV + NUM_CP0 + 20;
    localparam int N_APB   = 2 + 2 * NUM_CP0;
    localparam int TIMEOUT_CYCLES = N_INSTR + 2 * N_APB + 100;

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic                  in_valid;
    decoded_op_t           in_op;
    alufunc_t              in_func;
    alusrc_t               in_alusrc;
    logic                  in_shamt_valid;
    logic [4:0]            in_shamt;
    word_t                 in_imm;
    reg_addr_t             in_srcrega;
    reg_addr_t             in_srcregb;
    reg_addr_t             in_destreg;
    logic                  in_readya;
    logic                  in_readyb;
    word_t                 in_srca;
    word_t                 in_srcb;
    logic                  in_regwrite;
    word_t                 in_pcplus4;
    logic [CP0_ADDR_W-1:0] in_cp0_addr;
    logic                  out_valid;
    word_t                 out_result;
    word_t                 out_hiresult;
    word_t                 out_loresult;
    reg_addr_t             out_destreg;
    logic                  out_regwrite;
    logic                  out_exception_of;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [APB_ADDR_W-1:0] paddr;
    word_t                 pwdata;
    word_t                 prdata;
    logic                  pready;
    word_t                 cp0_written [NUM_CP0];
    int unsigned           apb_errors = 0;
    int unsigned           assert_errors;

    delay_stage u_delay_stage (.*);

    bind delay_stage delay_stage_sva u_delay_stage_sva (.*);

    always #5 clk = ~clk;

    task automatic issue(input decoded_op_t op, input alufunc_t func, input alusrc_t src,
                         input reg_addr_t ra, input reg_addr_t rb, input reg_addr_t rd,
                         input logic rdy_a, input logic rdy_b, input word_t a, input word_t b,
                         input word_t imm, input logic wr, input logic [CP0_ADDR_W-1:0] cp0);
        @(posedge clk);
        in_valid       <= 1'b1;
        in_op          <= op;
        in_func        <= func;
        in_alusrc      <= src;
        in_shamt_valid <= (func inside {ALU_SLL, ALU_SRL, ALU_SRA}) && ($urandom_range(1, 0) == 1);
        in_shamt       <= 5'($urandom);
        in_imm         <= imm;
        in_srcrega     <= ra;
        in_srcregb     <= rb;
        in_destreg     <= rd;
        in_readya      <= rdy_a;
        in_readyb      <= rdy_b;
        in_srca        <= a;
        in_srcb        <= b;
        in_regwrite    <= wr;
        in_pcplus4     <= $urandom & 32'hffff_fffc;  // word aligned pc.
        in_cp0_addr    <= cp0;
    endtask

    task automatic idle();
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    task automatic random_alu(input logic rdy_a, input logic rdy_b);
        issue(OP_ALU, alufunc_t'(4'($urandom_range(14, 0))), alusrc_t'(1'($urandom)),
              5'($urandom), 5'($urandom), 5'($urandom), rdy_a, rdy_b,
              $urandom, $urandom, $urandom, 1'b1, '0);
    endtask

    // or with a zero immediate brings a register out on out_result.
    task automatic read_back(input reg_addr_t r);
        issue(OP_ALU, ALU_OR, SRC_IMM, r, 5'd0, 5'd0, 1'b0, 1'b0, 32'h0, 32'h0, 32'h0, 1'b0, '0);
    endtask

    task automatic apb_write(input logic [APB_ADDR_W-1:0] addr, input word_t data);
        @(posedge clk);
        in_valid <= 1'b0;
        psel     <= 1'b1;
        penable  <= 1'b0;
        pwrite   <= 1'b1;
        paddr    <= addr;
        pwdata   <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_read(input logic [APB_ADDR_W-1:0] addr, input word_t expected);
        @(posedge clk);
        in_valid <= 1'b0;
        psel     <= 1'b1;
        penable  <= 1'b0;
        pwrite   <= 1'b0;
        paddr    <= addr;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);                                // prdata is settled mid access phase.
        if (prdata !== expected)
        begin
            apb_errors++;
            $display("mismatch t=%0t prdata got %h exp %h", $time, prdata, expected);
        end
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    initial
    begin
        #(TIMEOUT_CYCLES * 10);
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial
    begin
        void'($urandom(32'hf83b5dcd));
        rst_n          = 1'b0;
        in_valid       = 1'b0;
        in_op          = OP_ALU;
        in_func        = ALU_ADD;
        in_alusrc      = SRC_REGB;
        in_shamt_valid = 1'b0;
        in_shamt       = '0;
        in_imm         = '0;
        in_srcrega     = '0;
        in_srcregb     = '0;
        in_destreg     = '0;
        in_readya      = 1'b0;
        in_readyb      = 1'b0;
        in_srca        = '0;
        in_srcb        = '0;
        in_regwrite    = 1'b0;
        in_pcplus4     = '0;
        in_cp0_addr    = '0;
        psel           = 1'b0;
        penable        = 1'b0;
        pwrite         = 1'b0;
        paddr          = '0;
        pwdata         = '0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        repeat (8) random_alu(1'b0, 1'b0);             // stage still disabled here.
        apb_write(CP0_ENABLE_ADDR, 32'h1);
        apb_read(CP0_ENABLE_ADDR, 32'h1);

        repeat (N_RAND)
        begin
            random_alu(1'b0, 1'b0);
            if ($urandom_range(3, 0) == 0)
                idle();                                // gaps so out_valid has to follow in_valid.
        end
        for (int r = 0; r < NUM_REGS; r++)
            read_back(5'(r));
        repeat (N_READY) random_alu(1'($urandom), 1'($urandom));

        repeat (N_MOV)
        begin
            issue(($urandom_range(1, 0) == 1) ? OP_MOVZ : OP_MOVN, ALU_PASSB, SRC_REGB,
                  5'($urandom), 5'($urandom), 5'($urandom), 1'b0, 1'($urandom),
                  $urandom, ($urandom_range(1, 0) == 1) ? 32'h0 : $urandom, 32'h0, 1'b1, '0);
        end

        for (int i = 0; i < NUM_CP0; i++)
        begin
            cp0_written[i] = $urandom;
            apb_write(APB_ADDR_W'(i), cp0_written[i]);
        end
        for (int i = 0; i < NUM_CP0; i++)
            apb_read(APB_ADDR_W'(i), cp0_written[i]);
        for (int i = 0; i < NUM_CP0; i++)
        begin
            issue(OP_MFC0, ALU_PASSB, SRC_REGB, 5'd0, 5'd0, 5'(i + 8), 1'b0, 1'b0,
                  32'h0, 32'h0, 32'h0, 1'b1, CP0_ADDR_W'(i));
        end

        issue(OP_MTHI, ALU_PASSB, SRC_REGB, 5'd0, 5'd0, 5'd0, 1'b1, 1'b0,
              $urandom, 32'h0, 32'h0, 1'b0, '0);
        issue(OP_MTLO, ALU_PASSB, SRC_REGB, 5'd0, 5'd0, 5'd0, 1'b1, 1'b0,
              $urandom, 32'h0, 32'h0, 1'b0, '0);
        issue(OP_MFHI, ALU_PASSB, SRC_REGB, 5'd0, 5'd0, 5'd20, 1'b0, 1'b0,
              32'h0, 32'h0, 32'h0, 1'b1, '0);
        issue(OP_MFLO, ALU_PASSB, SRC_REGB, 5'd0, 5'd0, 5'd21, 1'b0, 1'b0,
              32'h0, 32'h0, 32'h0, 1'b1, '0);

        // both of these leave the signed range, so rd must keep its old value.
        issue(OP_ALU, ALU_ADD, SRC_REGB, 5'd0, 5'd0, 5'd5, 1'b1, 1'b1,
              32'h7fff_ffff, 32'h1, 32'h0, 1'b1, '0);
        issue(OP_ALU, ALU_SUB, SRC_REGB, 5'd0, 5'd0, 5'd6, 1'b1, 1'b1,
              32'h8000_0000, 32'h1, 32'h0, 1'b1, '0);
        for (int r = 0; r < NUM_REGS; r++)
            read_back(5'(r));

        idle();
        repeat (3) @(posedge clk);
        assert_errors = u_delay_stage.u_delay_stage_sva.fail_count;
        $display("errors: %0d assertion failures, %0d apb read-back mismatches",
                 assert_errors, apb_errors);
        if ((assert_errors == 0) && (apb_errors == 0))
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

//--- tb.f
verilog/mips_pkg.sv
verilog/alu.sv
verilog/delay_fu.sv
verilog/reg_file.sv
verilog/cp0_apb_regs.sv
verilog/delay_stage.sv
bench/delay_stage_sva.sv
bench/delay_stage_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the delay stage testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing -f tb.f --top-module delay_stage_tb

# A high error limit lets the run reach its own closing report after an assertion fails.
output=$(./obj_dir/Vdelay_stage_tb +verilator+error+limit+10000)
echo "$output"

echo "$output" | grep -qF '*** TEST PASSED ***'
